// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Geometry of the L1 data cache
`define L1_WAYS           4
`define L1_SETS           64
`define L1_LINE_BITS      128
`define L1_WORDS_PER_LINE 4

// CPU side widths
`define L1_ADDR_BITS      32
`define L1_WORD_BITS      32

`endif

// ==== cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    // Address split: tag | set | word offset | byte offset (ignored)
    typedef logic [$clog2(`L1_WAYS)-1:0]           way_idx_t;
    typedef logic [$clog2(`L1_SETS)-1:0]           set_idx_t;
    typedef logic [$clog2(`L1_WORDS_PER_LINE)-1:0] word_off_t;
    typedef logic [`L1_ADDR_BITS - $clog2(`L1_SETS) - $clog2(`L1_WORDS_PER_LINE)
                   - $clog2(`L1_WORD_BITS / 8) - 1:0] tag_t;

    typedef logic [`L1_LINE_BITS-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,       // Wait for a CPU cycle
        LOOKUP,     // Store results visible
        REFILL,     // Line read from memory
        FILL,       // Write fetched line into the stores
        WRITE_MEM,  // Single word write-through
        RESPOND     // Ack to the CPU
    } ctrl_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

endpackage

// ==== tag_store.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_store (
    input  logic                clk_i,
    input  logic                rst_n,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::tag_t     tag,
    input  logic                fill_en,
    input  logic                touch_en,
    input  cache_pkg::way_idx_t upd_way,
    output logic                hit,
    output cache_pkg::way_idx_t hit_way,
    output cache_pkg::way_idx_t victim_way
);
    import cache_pkg::*;

    logic [`L1_SETS-1:0] valid_q [`L1_WAYS];
    tag_t                tag_q   [`L1_WAYS][`L1_SETS];
    way_idx_t            order_q [`L1_SETS][`L1_WAYS];  // Slot 0 is most recent

    logic [`L1_WAYS-1:0] match;
    way_idx_t            match_way;
    way_idx_t            upd_pos;
    way_idx_t            new_order [`L1_WAYS];
    logic                upd_en;

    // Tag compare across all ways of the addressed set
    always_comb begin
        match_way = '0;
        for (int w = 0; w < `L1_WAYS; w++) begin
            match[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == tag);
            if (match[w]) begin
                match_way = way_idx_t'(w);
            end
        end
    end

    assign upd_en = fill_en | touch_en;

    // Move upd_way to the front, older entries slide back one slot
    always_comb begin
        upd_pos = way_idx_t'(`L1_WAYS - 1);
        for (int i = 0; i < `L1_WAYS; i++) begin
            if (order_q[set_idx][i] == upd_way) begin
                upd_pos = way_idx_t'(i);
            end
        end
        new_order[0] = upd_way;
        for (int i = 1; i < `L1_WAYS; i++) begin
            if (i <= int'(upd_pos)) begin
                new_order[i] = order_q[set_idx][i-1];
            end else begin
                new_order[i] = order_q[set_idx][i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `L1_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            for (int s = 0; s < `L1_SETS; s++) begin
                for (int i = 0; i < `L1_WAYS; i++) begin
                    order_q[s][i] <= way_idx_t'(i);  // Way 3 is first victim
                end
            end
        end else begin
            if (fill_en) begin
                valid_q[upd_way][set_idx] <= 1'b1;
            end
            if (upd_en) begin
                order_q[set_idx] <= new_order;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_en) begin
            tag_q[upd_way][set_idx] <= tag;
        end
    end

    // Registered lookup result
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            hit        <= 1'b0;
            hit_way    <= '0;
            victim_way <= '0;
        end else begin
            hit        <= |match;
            hit_way    <= match_way;
            victim_way <= order_q[set_idx][`L1_WAYS-1];  // Least recent way
        end
    end

    // Controller must never fill a tag that is already resident
    a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n)
        $onehot0(match))
        else $error("tag_store: several ways match in set %0d", set_idx);

endmodule

// ==== data_store.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module data_store (
    input  logic                     clk_i,
    input  logic                     rst_n,
    input  cache_pkg::set_idx_t      set_idx,
    input  cache_pkg::way_idx_t      way,
    input  cache_pkg::word_off_t     word_off,
    input  logic                     fill_en,
    input  cache_pkg::line_t         fill_line,
    input  logic                     word_wr_en,
    input  logic [`L1_WORD_BITS-1:0] wr_word,
    output logic [`L1_WORD_BITS-1:0] rd_word
);
    import cache_pkg::*;

    line_t                    lines_q [`L1_WAYS][`L1_SETS];
    logic [`L1_WORD_BITS-1:0] stored_word;
    logic [`L1_WORD_BITS-1:0] fill_word;

    // Word lane picked from the stored line and from the incoming one
    assign stored_word = lines_q[way][set_idx][word_off * `L1_WORD_BITS +: `L1_WORD_BITS];
    assign fill_word   = fill_line[word_off * `L1_WORD_BITS +: `L1_WORD_BITS];

    always_ff @(posedge clk_i) begin
        if (fill_en) begin
            lines_q[way][set_idx] <= fill_line;  // Whole line from memory
        end else if (word_wr_en) begin
            lines_q[way][set_idx][word_off * `L1_WORD_BITS +: `L1_WORD_BITS] <= wr_word;
        end
    end

    // On a fill the new word bypasses the array
    always_ff @(posedge clk_i) begin
        if (fill_en) begin
            rd_word <= fill_word;
        end else begin
            rd_word <= stored_word;
        end
    end

    // Fill and word update come from different controller states
    a_no_double_write: assert property (@(posedge clk_i) disable iff (!rst_n)
        !(fill_en && word_wr_en))
        else $error("data_store: fill and word write in the same cycle");

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_n,

    // CPU Wishbone slave
    input  logic                          cpu_cyc,
    input  logic                          cpu_stb,
    input  logic                          cpu_we,
    input  logic [`L1_ADDR_BITS-1:0]      cpu_adr,
    input  logic [`L1_WORD_BITS-1:0]      cpu_dat_w,
    output logic [`L1_WORD_BITS-1:0]      cpu_dat_r,
    output logic                          cpu_ack,

    // Memory Wishbone master
    output logic                          mem_cyc,
    output logic                          mem_stb,
    output logic                          mem_we,
    output logic [`L1_ADDR_BITS-1:0]      mem_adr,
    output cache_pkg::line_t              mem_dat_w,
    output logic [`L1_WORDS_PER_LINE-1:0] mem_sel,
    input  cache_pkg::line_t              mem_dat_r,
    input  logic                          mem_ack,

    // Store side
    input  logic                          hit,
    input  cache_pkg::way_idx_t           hit_way,
    input  cache_pkg::way_idx_t           victim_way,
    input  logic [`L1_WORD_BITS-1:0]      rd_word,
    output cache_pkg::set_idx_t           set_idx,
    output cache_pkg::tag_t               tag,
    output cache_pkg::word_off_t          word_off,
    output cache_pkg::way_idx_t           sel_way,
    output logic                          fill_en,
    output logic                          touch_en,
    output logic                          word_wr_en,
    output cache_pkg::line_t              fill_line,
    output logic [`L1_WORD_BITS-1:0]      wr_word
);
    import cache_pkg::*;

    localparam int OFF_LO = $clog2(`L1_WORD_BITS / 8);
    localparam int SET_LO = OFF_LO + $bits(word_off_t);
    localparam int TAG_LO = SET_LO + $bits(set_idx_t);

    ctrl_state_e                  state_q;
    ctrl_state_e                  state_d;
    logic                         req;
    logic [`L1_ADDR_BITS-1:0]     adr_q;
    logic [`L1_ADDR_BITS-1:0]     req_adr;
    logic [`L1_WORD_BITS-1:0]     dat_q;
    mem_op_e                      op_q;
    way_idx_t                     way_q;
    line_t                        line_q;
    logic [`L1_WORDS_PER_LINE-1:0] lane_sel;

    assign req = cpu_cyc & cpu_stb;

    // Stores see the live address in IDLE so LOOKUP has their result
    assign req_adr  = (state_q == IDLE) ? cpu_adr : adr_q;
    assign set_idx  = req_adr[SET_LO +: $bits(set_idx_t)];
    assign tag      = req_adr[TAG_LO +: $bits(tag_t)];
    assign word_off = req_adr[OFF_LO +: $bits(word_off_t)];

    // Way is only known in LOOKUP, held afterwards
    always_comb begin
        if (state_q == LOOKUP) begin
            sel_way = hit ? hit_way : victim_way;
        end else begin
            sel_way = way_q;
        end
    end

    always_comb begin
        state_d    = state_q;
        touch_en   = 1'b0;
        word_wr_en = 1'b0;
        case (state_q)
            IDLE: begin
                if (req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (op_q == OP_WRITE) begin
                    word_wr_en = hit;  // Write miss does not allocate
                    touch_en   = hit;
                    state_d    = WRITE_MEM;
                end else if (hit) begin
                    touch_en = 1'b1;
                    state_d  = RESPOND;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ack) begin
                    state_d = FILL;
                end
            end
            FILL:      state_d = RESPOND;
            WRITE_MEM: begin
                if (mem_ack) begin
                    state_d = RESPOND;
                end
            end
            RESPOND:   state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    assign fill_en   = (state_q == FILL);
    assign fill_line = line_q;
    assign wr_word   = dat_q;

    // One-hot lane for write-through
    always_comb begin
        for (int i = 0; i < `L1_WORDS_PER_LINE; i++) begin
            lane_sel[i] = (int'(word_off) == i);
        end
    end

    assign mem_cyc   = (state_q == REFILL) || (state_q == WRITE_MEM);
    assign mem_stb   = mem_cyc;
    assign mem_we    = (state_q == WRITE_MEM);
    assign mem_adr   = {adr_q[`L1_ADDR_BITS-1:SET_LO], {SET_LO{1'b0}}};  // Line aligned
    assign mem_dat_w = {`L1_WORDS_PER_LINE{dat_q}};
    assign mem_sel   = mem_we ? lane_sel : '1;

    assign cpu_ack   = (state_q == RESPOND);
    assign cpu_dat_r = rd_word;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req) begin
            adr_q <= cpu_adr;
            dat_q <= cpu_dat_w;
            op_q  <= cpu_we ? OP_WRITE : OP_READ;
        end
        if (state_q == LOOKUP) begin
            way_q <= sel_way;
        end
        if (state_q == REFILL && mem_ack) begin
            line_q <= mem_dat_r;
        end
    end

    // Ack only inside the master's cycle
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n)
        cpu_ack |-> cpu_cyc && cpu_stb)
        else $error("cache_ctrl: cpu_ack outside a CPU cycle");

    // Memory request held with cyc until acked
    a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
        mem_stb && !mem_ack |=> mem_stb && mem_cyc && $stable(mem_adr) && $stable(mem_we))
        else $error("cache_ctrl: memory request dropped before ack");

endmodule

// ==== l1_cache_top.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module l1_cache_top (
    input  logic                          clk_i,
    input  logic                          rst_n,

    // CPU side, 32-bit Wishbone classic
    input  logic                          cpu_cyc,
    input  logic                          cpu_stb,
    input  logic                          cpu_we,
    input  logic [`L1_ADDR_BITS-1:0]      cpu_adr,
    input  logic [`L1_WORD_BITS-1:0]      cpu_dat_w,
    output logic [`L1_WORD_BITS-1:0]      cpu_dat_r,
    output logic                          cpu_ack,

    // Memory side, 128-bit Wishbone classic
    output logic                          mem_cyc,
    output logic                          mem_stb,
    output logic                          mem_we,
    output logic [`L1_ADDR_BITS-1:0]      mem_adr,
    output cache_pkg::line_t              mem_dat_w,
    output logic [`L1_WORDS_PER_LINE-1:0] mem_sel,
    input  cache_pkg::line_t              mem_dat_r,
    input  logic                          mem_ack
);
    import cache_pkg::*;

    set_idx_t                 set_idx;
    tag_t                     tag;
    word_off_t                word_off;
    way_idx_t                 sel_way;
    way_idx_t                 hit_way;
    way_idx_t                 victim_way;
    logic                     hit;
    logic                     fill_en;
    logic                     touch_en;
    logic                     word_wr_en;
    line_t                    fill_line;
    logic [`L1_WORD_BITS-1:0] wr_word;
    logic [`L1_WORD_BITS-1:0] rd_word;

    tag_store u_tag_store (
        .clk_i(clk_i), .rst_n(rst_n), .set_idx(set_idx), .tag(tag),
        .fill_en(fill_en), .touch_en(touch_en), .upd_way(sel_way),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
    );

    data_store u_data_store (
        .clk_i(clk_i), .rst_n(rst_n), .set_idx(set_idx), .way(sel_way),
        .word_off(word_off), .fill_en(fill_en), .fill_line(fill_line),
        .word_wr_en(word_wr_en), .wr_word(wr_word), .rd_word(rd_word)
    );

    cache_ctrl u_cache_ctrl (
        .clk_i(clk_i), .rst_n(rst_n),
        .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
        .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_sel(mem_sel), .mem_dat_r(mem_dat_r),
        .mem_ack(mem_ack),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way), .rd_word(rd_word),
        .set_idx(set_idx), .tag(tag), .word_off(word_off), .sel_way(sel_way),
        .fill_en(fill_en), .touch_en(touch_en), .word_wr_en(word_wr_en),
        .fill_line(fill_line), .wr_word(wr_word)
    );

endmodule

// ==== tb_l1_cache.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_l1_cache;
    import cache_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 16;

    logic                          clk_i, rst_n, cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    logic [`L1_ADDR_BITS-1:0]      cpu_adr;
    logic [`L1_WORD_BITS-1:0]      cpu_dat_w, cpu_dat_r;
    logic                          mem_cyc, mem_stb, mem_we, mem_ack;
    logic [`L1_ADDR_BITS-1:0]      mem_adr;
    logic [`L1_WORDS_PER_LINE-1:0] mem_sel;
    line_t                         mem_dat_w, mem_dat_r;

    // Shadow of tags, valid bits and LRU order per set
    logic        model_valid [`L1_SETS][`L1_WAYS];
    tag_t        model_tag   [`L1_SETS][`L1_WAYS];
    way_idx_t    model_order [`L1_SETS][`L1_WAYS];  // Slot 0 is most recent
    logic [31:0] model_mem [logic [29:0]];  // Expected memory words written so far
    logic [31:0] slave_mem [logic [29:0]];  // Words the DUT really wrote
    mem_op_e     mon_op  [$];               // Memory cycles of the current request
    logic [31:0] mon_adr [$];
    logic [3:0]  mon_sel [$];
    line_t       mon_dat [$];
    int          seen;

    l1_cache_top u_l1_cache_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat ((NUM_RANDOM + NUM_DIRECTED) * 40) @(posedge clk_i);
        $display("Watchdog expired at %0t with a CPU request still open", $time);
        $display("ERRORS FOUND");
        $fatal(1, "Timeout");
    end

    // Untouched words get a pattern unique to their address
    function automatic logic [31:0] word_at(input logic from_slave, input logic [29:0] widx);
        if (from_slave && slave_mem.exists(widx)) begin
            return slave_mem[widx];
        end else if (!from_slave && model_mem.exists(widx)) begin
            return model_mem[widx];
        end
        return ({widx, 2'b00} * 32'h9e37_79b1) ^ {2'b00, widx};
    endfunction

    function automatic line_t line_at(input logic from_slave, input logic [31:0] adr);
        line_t l;
        for (int i = 0; i < `L1_WORDS_PER_LINE; i++) begin
            l[i*32 +: 32] = word_at(from_slave, {adr[31:4], 2'(i)});
        end
        return l;
    endfunction

    function automatic logic [31:0] pool_adr(input int t, input set_idx_t s, input word_off_t off);
        return {tag_t'(32'h1a2b + t * 32'h3f07), s, off, 2'($urandom_range(3, 0))};
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_op(input string name, input mem_op_e got, input mem_op_e exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic expect_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("At %0t the %s made %0d memory cycles instead of %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic model_touch(input set_idx_t s, input way_idx_t w);
        int pos;
        pos = `L1_WAYS - 1;
        for (int i = 0; i < `L1_WAYS; i++) begin
            if (model_order[s][i] == w) pos = i;
        end
        for (int i = pos; i > 0; i--) begin
            model_order[s][i] = model_order[s][i-1];  // Younger entries age by one
        end
        model_order[s][0] = w;
    endtask

    task automatic apply_reset();
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_n = 1'b1;
        for (int s = 0; s < `L1_SETS; s++) begin
            for (int w = 0; w < `L1_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_order[s][w] = way_idx_t'(w);  // Way 3 is least recent
            end
        end
        check_word("cpu_ack", 32'(cpu_ack), 32'h0);
        check_word("mem_cyc", 32'(mem_cyc), 32'h0);
    endtask

    // One CPU transfer predicted by the model before it is driven
    task automatic do_req(input mem_op_e op, input logic [31:0] adr, output int cycles);
        set_idx_t    s;
        way_idx_t    way;
        logic        hit;
        logic [31:0] wdat;
        logic [31:0] exp_rd;
        logic [31:0] line_adr;

        s        = adr[9:4];
        line_adr = {adr[31:4], 4'h0};
        wdat     = $urandom;
        exp_rd   = word_at(1'b0, adr[31:2]);
        hit      = 1'b0;
        way      = model_order[s][`L1_WAYS-1];  // Victim if this read misses
        for (int w = 0; w < `L1_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == adr[31:10]) begin
                hit = 1'b1;
                way = way_idx_t'(w);
            end
        end
        if (op == OP_READ && !hit) begin
            model_valid[s][way] = 1'b1;
            model_tag[s][way]   = adr[31:10];
        end
        if (op == OP_READ || hit) model_touch(s, way);  // Write miss keeps the order
        if (op == OP_WRITE) model_mem[adr[31:2]] = wdat;
        mon_op.delete();
        mon_adr.delete();
        mon_sel.delete();
        mon_dat.delete();

        @(posedge clk_i);
        #1;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = (op == OP_WRITE);
        cpu_adr   = adr;
        cpu_dat_w = wdat;
        do begin
            @(posedge clk_i);
            #1;
        end while (!cpu_ack);

        cycles = mon_op.size();
        expect_cycles("request", cycles, (op == OP_WRITE || !hit) ? 1 : 0);
        if (op == OP_READ) check_word("cpu_dat_r", cpu_dat_r, exp_rd);
        if (cycles == 1) begin
            check_op("mem_we", mon_op[0], op);
            check_word("mem_adr", mon_adr[0], line_adr);
            check_word("mem_sel", 32'(mon_sel[0]), (op == OP_READ) ? 32'hf : 32'h1 << adr[3:2]);
        end
        if (op == OP_WRITE) begin
            check_word("mem_dat_w lane", mon_dat[0][adr[3:2]*32 +: 32], wdat);
            check_line("memory line", line_at(1'b1, line_adr), line_at(1'b0, line_adr));
        end
        @(posedge clk_i);
        #1;
        check_word("cpu_ack", 32'(cpu_ack), 32'h0);  // Ack lasts one cycle
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    // Memory slave with 0 to 3 wait states per transfer
    initial begin
        int   waits;
        logic busy;
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        busy      = 1'b0;
        waits     = 0;
        forever begin
            @(posedge clk_i);
            #1;
            mem_ack = 1'b0;
            if (mem_stb && !mem_cyc) begin
                $display("At %0t mem_stb is high outside a memory cycle", $time);
                stop_run();
            end
            if (mem_cyc && mem_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = $urandom_range(3, 0);
                end
                if (waits == 0) begin
                    mon_op.push_back(mem_we ? OP_WRITE : OP_READ);
                    mon_adr.push_back(mem_adr);
                    mon_sel.push_back(mem_sel);
                    mon_dat.push_back(mem_dat_w);
                    for (int i = 0; i < `L1_WORDS_PER_LINE; i++) begin
                        if (mem_we && mem_sel[i]) begin
                            slave_mem[{mem_adr[31:4], 2'(i)}] = mem_dat_w[i*32 +: 32];
                        end
                    end
                    mem_dat_r = line_at(1'b1, mem_adr);
                    mem_ack   = 1'b1;
                    busy      = 1'b0;
                end else begin
                    waits--;
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h26e6_6bfd));
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        apply_reset();

        // Miss followed by another word of the same line
        a = pool_adr(0, 6'd5, 2'd1);
        do_req(OP_READ, a, seen);
        do_req(OP_READ, {a[31:4], 4'h8}, seen);
        expect_cycles("repeat read", seen, 0);

        // Write hit and write miss with a read back of each
        do_req(OP_WRITE, a, seen);
        do_req(OP_READ, a, seen);
        b = pool_adr(1, 6'd5, 2'd3);
        do_req(OP_WRITE, b, seen);
        do_req(OP_READ, b, seen);
        expect_cycles("read after write miss", seen, 1);

        // Fifth tag in a set pushes out the first
        for (int t = 0; t < 5; t++) begin
            do_req(OP_READ, pool_adr(t, 6'd9, 2'd0), seen);
        end
        do_req(OP_READ, pool_adr(0, 6'd9, 2'd2), seen);
        expect_cycles("read of evicted line", seen, 1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            do_req(($urandom_range(99, 0) < 45) ? OP_WRITE : OP_READ,
                   pool_adr($urandom_range(5, 0), set_idx_t'(6'd3 + 6'd14 * $urandom_range(2, 0)),
                            word_off_t'($urandom_range(3, 0))), seen);
        end

        apply_reset();
        for (int t = 0; t < 4; t++) begin
            do_req(OP_READ, pool_adr(t, 6'd17, word_off_t'($urandom_range(3, 0))), seen);
            expect_cycles("read after reset", seen, 1);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
cache_pkg.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
l1_cache_top.sv
tb_l1_cache.sv

// ==== Makefile ====
# Verilator flow for the L1 cache testbench
TOP = tb_l1_cache
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

# The run passes only if the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
